// ==== sim/mmsaStimulus.txt ====
// Matrix lines: X0..X3 then W0..W3, 16 hex elements each, row-major
// Request lines: input index, weight index, then expected sums for t = 0..6
0001 0000 0000 0000 0000 0001 0000 0000 0000 0000 0001 0000 0000 0000 0000 0001
8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
0100 0002 ff00 0011 fe00 0040 0008 0000 0001 0002 0003 0004 8000 0005 0006 0007
ffff 0000 0000 0000 0000 ffff 0000 0000 0000 0000 ffff 0000 0000 0000 0000 ffff
0003 0005 0002 0010 fffb 0001 0004 0100 0007 fffa 0020 0000 0009 0030 0000 1234
8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
0001 0000 0000 0000 0000 0001 0000 0000 0000 0000 0001 0000 0000 0000 0000 0001
7fff 0000 0001 0000 0002 7fff 0000 ffff 0000 0003 7fff 0000 0000 0000 0004 7fff
0 0 3 0 a 17 150 0 1234
1 1 100000000 200000000 300000000 400000000 300000000 200000000 100000000
2 2 100 fffffffe02 ffffffff41 ffffff801b 8 a 7
3 3 ffffff8001 fffffffffe ffffff8000 fffffffffd ffffff8002 fffffffffc ffffff8001
0 3 7fff 2 8000 3 7ffe 4 7fff
3 0 fffffffffd 0 fffffffff6 ffffffffe9 fffffffeb0 0 ffffffedcc
1 0 fffff90000 ffffe10000 ffffce0000 fff62c0000 fff6330000 fff64b0000 fff65e0000

// ==== mmsaTop.f ====
src/mmsaPkg.sv
src/sumIf.sv
src/processingElement.sv
src/matrixStore.sv
src/mmsaCtrl.sv
src/systolicArray.sv
src/resultSerializer.sv
src/mmsaTop.sv
sim/mmsaTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := mmsaTb
FILELIST   := mmsaTop.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
PASS_MSG   := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/mmsaTb.sv ====
`timescale 1ns/1ps

module mmsaTb
    import mmsaPkg::*;
();

    localparam int ArrayDim  = 4;
    localparam int BankDepth = 4;
    localparam int IdxWidth  = 2;
    localparam int MatSize   = ArrayDim * ArrayDim;
    localparam int NumSums   = 2 * ArrayDim - 1;
    localparam int NumReq    = 7;
    localparam int ReqBase   = 2 * BankDepth * MatSize;
    localparam int ReqWords  = 2 + NumSums;
    localparam int WaitLimit = 200;
    localparam int MaxBits   = NumSums * (LenWidth + AccWidth) + 8;

    logic clk;
    logic rst_n;
    logic i_inValid;
    logic i_inValid2;
    logic i_matrix;
    logic i_iMatIdx;
    logic i_wMatIdx;
    logic o_outValid;
    logic o_outValue;

    logic [AccWidth-1:0] stimMem [ReqBase + NumReq * ReqWords];
    acc_t                expSums [NumSums];
    logic                burst [$];
    integer              seed;
    int                  mismatchCnt;
    int                  stimErrCnt;
    int                  failCnt;

    mmsaTop i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_inValid  (i_inValid),
        .i_inValid2 (i_inValid2),
        .i_matrix   (i_matrix),
        .i_iMatIdx  (i_iMatIdx),
        .i_wMatIdx  (i_wMatIdx),
        .o_outValid (o_outValid),
        .o_outValue (o_outValue)
    );

    always #10 clk = ~clk;

    // ----------------------------------------------------------
    // Compare tasks and reference model
    // ----------------------------------------------------------
    task automatic checkLen(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            mismatchCnt++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkSum(input string name, input acc_t got, input acc_t exp);
        if (got !== exp) begin
            mismatchCnt++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Highest set bit plus one, zero for a zero sum
    function automatic len_t lengthOf(input acc_t value);
        for (int i = AccWidth - 1; i >= 0; i--) begin
            if (value[i]) begin
                return len_t'(i + 1);
            end
        end
        return '0;
    endfunction

    // Sum of (X*W)[r][c] over r + c == t
    function automatic acc_t refSum(input int xIdx, input int wIdx, input int t);
        acc_t  acc;
        elem_t a;
        elem_t b;
        acc = '0;
        for (int r = 0; r < ArrayDim; r++) begin
            for (int c = 0; c < ArrayDim; c++) begin
                if (r + c == t) begin
                    for (int k = 0; k < ArrayDim; k++) begin
                        a = elem_t'(stimMem[xIdx * MatSize + r * ArrayDim + k]);
                        b = elem_t'(stimMem[(BankDepth + wIdx) * MatSize + k * ArrayDim + c]);
                        acc = acc + acc_t'(a) * acc_t'(b);
                    end
                end
            end
        end
        return acc;
    endfunction

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            if (o_outValid) begin
                failCnt++;
                $display("o_outValid high at %0t while no burst was due", $time);
            end
        end
    endtask

    task automatic loadBanks();
        logic [AccWidth-1:0] word;
        for (int w = 0; w < ReqBase; w++) begin
            word = stimMem[w];
            for (int b = ElemWidth - 1; b >= 0; b--) begin
                @(negedge clk);
                if (o_outValid) begin
                    failCnt++;
                    $display("o_outValid high at %0t during the load phase", $time);
                end
                i_inValid = 1'b1;
                i_matrix  = word[b];
            end
        end
        @(negedge clk);
        i_inValid = 1'b0;
        i_matrix  = 1'b0;
    endtask

    task automatic sendRequest(input int xIdx, input int wIdx);
        logic [IdxWidth-1:0] xBits;
        logic [IdxWidth-1:0] wBits;
        xBits = IdxWidth'(xIdx);
        wBits = IdxWidth'(wIdx);
        for (int b = IdxWidth - 1; b >= 0; b--) begin
            @(negedge clk);
            i_inValid2 = 1'b1;
            i_iMatIdx  = xBits[b];
            i_wMatIdx  = wBits[b];
        end
        @(negedge clk);
        i_inValid2 = 1'b0;
        i_iMatIdx  = 1'b0;
        i_wMatIdx  = 1'b0;
    endtask

    task automatic collectBurst(input int q);
        int waitCnt;
        burst.delete();
        waitCnt = 0;
        while (!o_outValid && waitCnt < WaitLimit) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!o_outValid) begin
            failCnt++;
            $display("Request %0d: no output burst within %0d cycles", q, WaitLimit);
        end
        while (o_outValid && burst.size() < MaxBits) begin
            burst.push_back(o_outValue);
            @(negedge clk);
        end
        if (o_outValid) begin
            failCnt++;
            $display("Request %0d: o_outValid still high after %0d bits", q, MaxBits);
        end
    endtask

    // Length field MSB first, then that many value bits
    task automatic checkBurst(input int q);
        int   pos;
        int   total;
        len_t gotLen;
        len_t expLen;
        acc_t gotVal;
        pos   = 0;
        total = 0;
        for (int t = 0; t < NumSums; t++) begin
            expLen = lengthOf(expSums[t]);
            total  = total + LenWidth + int'(expLen);
            if (pos + LenWidth > burst.size()) begin
                failCnt++;
                $display("Request %0d: burst ended before the length of sum %0d", q, t);
                return;
            end
            gotLen = '0;
            for (int i = 0; i < LenWidth; i++) begin
                gotLen = {gotLen[LenWidth-2:0], burst[pos]};
                pos++;
            end
            checkLen($sformatf("req%0d len[%0d]", q, t), gotLen, expLen);
            if (pos + int'(gotLen) > burst.size()) begin
                failCnt++;
                $display("Request %0d: burst ended inside the value of sum %0d", q, t);
                return;
            end
            gotVal = '0;
            for (int i = 0; i < int'(gotLen); i++) begin
                gotVal = {gotVal[AccWidth-2:0], burst[pos]};
                pos++;
            end
            checkSum($sformatf("req%0d sum[%0d]", q, t), gotVal, expSums[t]);
        end
        if (burst.size() != total) begin
            mismatchCnt++;
            $display("MISMATCH at %0t: req%0d burst bits got %0d expected %0d",
                     $time, q, burst.size(), total);
        end
    endtask

    task automatic runRequest(input int q);
        int   base;
        int   xIdx;
        int   wIdx;
        acc_t model;
        base = ReqBase + q * ReqWords;
        xIdx = int'(stimMem[base]);
        wIdx = int'(stimMem[base + 1]);
        for (int t = 0; t < NumSums; t++) begin
            expSums[t] = acc_t'(stimMem[base + 2 + t]);
            model      = refSum(xIdx, wIdx, t);
            if (model !== expSums[t]) begin
                stimErrCnt++;
                $display("Stimulus error: request %0d sum %0d is %h in the file, matrices give %h",
                         q, t, expSums[t], model);
            end
        end
        sendRequest(xIdx, wIdx);
        collectBurst(q);
        checkBurst(q);
    endtask

    initial begin
        int gap;
        clk         = 1'b0;
        rst_n       = 1'b0;
        i_inValid   = 1'b0;
        i_inValid2  = 1'b0;
        i_matrix    = 1'b0;
        i_iMatIdx   = 1'b0;
        i_wMatIdx   = 1'b0;
        seed        = 32'ha80f_5d6c;
        mismatchCnt = 0;
        stimErrCnt  = 0;
        failCnt     = 0;
        $readmemh("sim/mmsaStimulus.txt", stimMem);

        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        idleCycles(3);
        loadBanks();
        idleCycles(4);

        // Requests reuse the same load, with random idle gaps
        for (int q = 0; q < NumReq; q++) begin
            gap = int'($unsigned($random(seed)) % 8);
            idleCycles(gap + 1);
            runRequest(q);
        end

        $display("Errors: %0d mismatches, %0d stimulus errors, %0d other failures",
                 mismatchCnt, stimErrCnt, failCnt);
        if (mismatchCnt == 0 && stimErrCnt == 0 && failCnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== src/mmsaTop.sv ====
`timescale 1ns/1ps

module mmsaTop
    import mmsaPkg::*;
#(
    parameter int ArrayDim  = 4,
    parameter int BankDepth = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic i_inValid,
    input  logic i_inValid2,
    input  logic i_matrix,
    input  logic i_iMatIdx,
    input  logic i_wMatIdx,
    output logic o_outValid,
    output logic o_outValue
);

    localparam int IdxWidth = (BankDepth > 1) ? $clog2(BankDepth) : 1;

    logic [IdxWidth-1:0] iSel;
    logic [IdxWidth-1:0] wSel;
    logic                computeStart;
    logic                serDone;
    elem_t               xMat [ArrayDim][ArrayDim];
    elem_t               wMat [ArrayDim][ArrayDim];

    sumIf #(.ArrayDim(ArrayDim)) sums ();

    mmsaCtrl #(.ArrayDim(ArrayDim), .BankDepth(BankDepth)) uCtrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_inValid      (i_inValid),
        .i_inValid2     (i_inValid2),
        .i_iMatIdx      (i_iMatIdx),
        .i_wMatIdx      (i_wMatIdx),
        .i_serDone      (serDone),
        .o_iSel         (iSel),
        .o_wSel         (wSel),
        .o_computeStart (computeStart)
    );

    matrixStore #(.ArrayDim(ArrayDim), .BankDepth(BankDepth)) uStore (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_inValid (i_inValid),
        .i_matrix  (i_matrix),
        .i_iSel    (iSel),
        .i_wSel    (wSel),
        .o_xMat    (xMat),
        .o_wMat    (wMat)
    );

    systolicArray #(.ArrayDim(ArrayDim)) uArray (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_computeStart (computeStart),
        .i_xMat         (xMat),
        .i_wMat         (wMat),
        .sums           (sums.producer)
    );

    resultSerializer #(.ArrayDim(ArrayDim)) uSer (
        .clk        (clk),
        .rst_n      (rst_n),
        .sums       (sums.consumer),
        .o_outValid (o_outValid),
        .o_outValue (o_outValue),
        .o_serDone  (serDone)
    );

endmodule

// ==== src/resultSerializer.sv ====
`timescale 1ns/1ps

module resultSerializer
    import mmsaPkg::*;
#(
    parameter int ArrayDim = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    sumIf.consumer sums,
    output logic   o_outValid,
    output logic   o_outValue,
    output logic   o_serDone
);

    localparam int NumSums     = 2 * ArrayDim - 1;
    localparam int SumIdxWidth = $clog2(2 * ArrayDim);

    acc_t sumBuf [NumSums];
    len_t lenBuf [NumSums];

    logic                   sending;
    logic                   inValue;
    logic [SumIdxWidth-1:0] entry;
    len_t                   bitPos;
    len_t                   curLen;
    logic                   curBit;
    logic                   lastEntry;

    // Position of the highest set bit plus one
    function automatic len_t bitLength(input acc_t value);
        len_t len;
        len = '0;
        for (int i = 0; i < AccWidth; i++) begin
            if (value[i]) begin
                len = len_t'(i + 1);
            end
        end
        return len;
    endfunction

    always_ff @(posedge clk) begin
        if (sums.sumValid) begin
            sumBuf[sums.sumIdx] <= sums.sumValue;
            lenBuf[sums.sumIdx] <= bitLength(sums.sumValue);
        end
    end

    // ----------------------------------------------------------
    // Output walk: length field, then value bits
    // ----------------------------------------------------------
    assign curLen    = lenBuf[entry];
    assign curBit    = inValue ? sumBuf[entry][bitPos] : curLen[bitPos[LenBitIdxWidth-1:0]];
    assign lastEntry = (entry == SumIdxWidth'(NumSums - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sending <= 1'b0;
            inValue <= 1'b0;
            entry   <= '0;
            bitPos  <= '0;
        end else if (sums.sumValid && sums.sumLast) begin
            sending <= 1'b1;
            inValue <= 1'b0;
            entry   <= '0;
            bitPos  <= len_t'(LenWidth - 1);
        end else if (sending) begin
            if (bitPos != '0) begin
                bitPos <= bitPos - 1'b1;
            end else if (!inValue && curLen != '0) begin
                inValue <= 1'b1;
                bitPos  <= curLen - 1'b1;
            end else if (lastEntry) begin
                sending <= 1'b0;
            end else begin
                entry   <= entry + 1'b1;
                inValue <= 1'b0;
                bitPos  <= len_t'(LenWidth - 1);
            end
        end
    end

    assign o_outValid = sending;
    assign o_outValue = sending && curBit;
    // Zero-length entry ends right after its length field
    assign o_serDone  = sending && lastEntry && (bitPos == '0) && (inValue || curLen == '0);

    // New results must not land while a burst is going out
    assert property (@(posedge clk) disable iff (!rst_n)
        sums.sumValid |-> !o_outValid);

endmodule

// ==== src/systolicArray.sv ====
`timescale 1ns/1ps

module systolicArray
    import mmsaPkg::*;
#(
    parameter int ArrayDim = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_computeStart,
    input  elem_t       i_xMat [ArrayDim][ArrayDim],
    input  elem_t       i_wMat [ArrayDim][ArrayDim],
    sumIf.producer      sums
);

    localparam int LastCnt     = 3 * ArrayDim - 2;
    localparam int CntWidth    = $clog2(3 * ArrayDim);
    localparam int SumIdxWidth = $clog2(2 * ArrayDim);

    logic                running;
    logic [CntWidth-1:0] feedCnt;
    elem_t               actIn   [ArrayDim][ArrayDim+1];
    acc_t                partIn  [ArrayDim+1][ArrayDim];
    acc_t                diagSum;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            feedCnt <= '0;
        end else if (i_computeStart) begin
            running <= 1'b1;
            feedCnt <= '0;
        end else if (running) begin
            running <= (feedCnt != CntWidth'(LastCnt));
            feedCnt <= feedCnt + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Skewed feed: row k sees column k of X, k cycles late
    // ----------------------------------------------------------
    for (genvar k = 0; k < ArrayDim; k++) begin : gFeed
        assign actIn[k][0]  = (running && int'(feedCnt) >= k && int'(feedCnt) < k + ArrayDim)
                            ? i_xMat[int'(feedCnt) - k][k] : '0;
        assign partIn[0][k] = '0;
    end

    for (genvar r = 0; r < ArrayDim; r++) begin : gRow
        for (genvar c = 0; c < ArrayDim; c++) begin : gCol
            processingElement uPe (
                .clk       (clk),
                .rst_n     (rst_n),
                .i_act     (actIn[r][c]),
                .i_weight  (i_wMat[r][c]),
                .i_partial (partIn[r][c]),
                .o_partial (partIn[r+1][c]),
                .o_act     (actIn[r][c+1])
            );
        end
    end

    // Bottom row holds one anti-diagonal of X*W per cycle
    always_comb begin
        diagSum = '0;
        for (int c = 0; c < ArrayDim; c++) begin
            diagSum = diagSum + partIn[ArrayDim][c];
        end
    end

    always_ff @(posedge clk) begin
        sums.sumValue <= diagSum;
        sums.sumIdx   <= SumIdxWidth'(int'(feedCnt) - ArrayDim);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sums.sumValid <= 1'b0;
            sums.sumLast  <= 1'b0;
        end else begin
            sums.sumValid <= running && int'(feedCnt) >= ArrayDim;
            sums.sumLast  <= running && (feedCnt == CntWidth'(LastCnt));
        end
    end

endmodule

// ==== src/mmsaCtrl.sv ====
`timescale 1ns/1ps

module mmsaCtrl
    import mmsaPkg::*;
#(
    parameter int ArrayDim  = 4,
    parameter int BankDepth = 4
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        i_inValid,
    input  logic                                        i_inValid2,
    input  logic                                        i_iMatIdx,
    input  logic                                        i_wMatIdx,
    input  logic                                        i_serDone,
    output logic [((BankDepth > 1) ? $clog2(BankDepth) : 1)-1:0] o_iSel,
    output logic [((BankDepth > 1) ? $clog2(BankDepth) : 1)-1:0] o_wSel,
    output logic                                        o_computeStart
);

    localparam int IdxWidth      = (BankDepth > 1) ? $clog2(BankDepth) : 1;
    // Start strobe to first serial bit, in cycles
    localparam int ComputeCycles = 3 * ArrayDim;
    localparam int CmpCntWidth   = $clog2(ComputeCycles + 1);

    ctrlState_t             state;
    ctrlState_t             nextState;
    logic [CmpCntWidth-1:0] cmpCnt;
    logic                   idxShift;

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (i_inValid) begin
                    nextState = LOAD;
                end else if (i_inValid2) begin
                    nextState = REQ;
                end
            end
            LOAD:     nextState = i_inValid ? LOAD : WAIT_REQ;
            WAIT_REQ: nextState = i_inValid2 ? REQ : WAIT_REQ;
            REQ:      nextState = i_inValid2 ? REQ : COMPUTE;
            COMPUTE:  nextState = (cmpCnt == CmpCntWidth'(ComputeCycles)) ? OUTPUT : COMPUTE;
            OUTPUT:   nextState = i_serDone ? IDLE : OUTPUT;
            default:  nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmpCnt         <= '0;
            o_computeStart <= 1'b0;
        end else begin
            cmpCnt         <= (state == COMPUTE) ? cmpCnt + 1'b1 : '0;
            o_computeStart <= (state == REQ) && !i_inValid2;
        end
    end

    // ----------------------------------------------------------
    // Index capture, MSB first
    // ----------------------------------------------------------
    assign idxShift = i_inValid2 && (state inside {IDLE, WAIT_REQ, REQ});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_iSel <= '0;
            o_wSel <= '0;
        end else if (idxShift) begin
            o_iSel <= IdxWidth'({o_iSel, i_iMatIdx});
            o_wSel <= IdxWidth'({o_wSel, i_wMatIdx});
        end
    end

    // A new request may not overlap a running one
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_inValid2) |-> !(state inside {COMPUTE, OUTPUT}));

endmodule

// ==== src/matrixStore.sv ====
`timescale 1ns/1ps

module matrixStore
    import mmsaPkg::*;
#(
    parameter int ArrayDim  = 4,
    parameter int BankDepth = 4
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        i_inValid,
    input  logic                                        i_matrix,
    input  logic [((BankDepth > 1) ? $clog2(BankDepth) : 1)-1:0] i_iSel,
    input  logic [((BankDepth > 1) ? $clog2(BankDepth) : 1)-1:0] i_wSel,
    output elem_t                                       o_xMat [ArrayDim][ArrayDim],
    output elem_t                                       o_wMat [ArrayDim][ArrayDim]
);

    localparam int IdxWidth    = (BankDepth > 1) ? $clog2(BankDepth) : 1;
    localparam int DimWidth    = (ArrayDim > 1) ? $clog2(ArrayDim) : 1;
    localparam int MatCntWidth = $clog2(2 * BankDepth + 1);

    logic [BitCntWidth-1:0] bitCnt;
    logic [DimWidth-1:0]    colCnt;
    logic [DimWidth-1:0]    rowCnt;
    logic [MatCntWidth-1:0] matCnt;
    logic [ElemWidth-2:0]   elemShift;
    logic                   elemDone;
    elem_t                  newElem;

    elem_t inBank [BankDepth][ArrayDim][ArrayDim];
    elem_t wBank  [BankDepth][ArrayDim][ArrayDim];

    // MSB first, so the current bit completes the word
    assign newElem  = elem_t'({elemShift, i_matrix});
    assign elemDone = i_inValid && (bitCnt == BitCntWidth'(ElemWidth - 1));

    always_ff @(posedge clk) begin
        if (i_inValid) begin
            elemShift <= newElem[ElemWidth-2:0];
        end
    end

    // Bit, element and matrix counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bitCnt <= '0;
            colCnt <= '0;
            rowCnt <= '0;
            matCnt <= '0;
        end else if (!i_inValid) begin
            bitCnt <= '0;
            colCnt <= '0;
            rowCnt <= '0;
            matCnt <= '0;
        end else if (elemDone) begin
            bitCnt <= '0;
            if (colCnt == DimWidth'(ArrayDim - 1)) begin
                colCnt <= '0;
                if (rowCnt == DimWidth'(ArrayDim - 1)) begin
                    rowCnt <= '0;
                    matCnt <= matCnt + 1'b1;
                end else begin
                    rowCnt <= rowCnt + 1'b1;
                end
            end else begin
                colCnt <= colCnt + 1'b1;
            end
        end else begin
            bitCnt <= bitCnt + 1'b1;
        end
    end

    // Input matrices first, then the weight matrices
    always_ff @(posedge clk) begin
        if (elemDone && matCnt < MatCntWidth'(BankDepth)) begin
            inBank[IdxWidth'(matCnt)][rowCnt][colCnt] <= newElem;
        end else if (elemDone && matCnt < MatCntWidth'(2 * BankDepth)) begin
            wBank[IdxWidth'(matCnt - MatCntWidth'(BankDepth))][rowCnt][colCnt] <= newElem;
        end
    end

    assign o_xMat = inBank[i_iSel];
    assign o_wMat = wBank[i_wSel];

    // Load burst must stop after the last weight matrix
    assert property (@(posedge clk) disable iff (!rst_n)
        matCnt <= MatCntWidth'(2 * BankDepth));

endmodule

// ==== src/processingElement.sv ====
`timescale 1ns/1ps

module processingElement
    import mmsaPkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  elem_t i_act,
    input  elem_t i_weight,
    input  acc_t  i_partial,
    output acc_t  o_partial,
    output elem_t o_act
);

    // MAC with the product sign-extended to the sum width
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_partial <= '0;
            o_act     <= '0;
        end else begin
            o_partial <= i_act * i_weight + i_partial;
            o_act     <= i_act;
        end
    end

endmodule

// ==== src/sumIf.sv ====
`timescale 1ns/1ps

interface sumIf
    import mmsaPkg::*;
#(
    parameter int ArrayDim = 4
) ();

    logic                          sumValid;
    logic [$clog2(2*ArrayDim)-1:0] sumIdx;
    acc_t                          sumValue;
    logic                          sumLast;

    modport producer (
        output sumValid, sumIdx, sumValue, sumLast
    );

    modport consumer (
        input sumValid, sumIdx, sumValue, sumLast
    );

endinterface

// ==== src/mmsaPkg.sv ====
package mmsaPkg;

    // ----------------------------------------------------------
    // Data widths
    // ----------------------------------------------------------
    localparam int ElemWidth = 16;
    localparam int AccWidth  = 40;
    localparam int LenWidth  = 6;

    // Counter widths that follow from the data widths
    localparam int BitCntWidth    = $clog2(ElemWidth);
    localparam int LenBitIdxWidth = $clog2(LenWidth);

    typedef logic signed [ElemWidth-1:0] elem_t;
    typedef logic signed [AccWidth-1:0]  acc_t;
    typedef logic        [LenWidth-1:0]  len_t;

    // Controller phases
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        WAIT_REQ,
        REQ,
        COMPUTE,
        OUTPUT
    } ctrlState_t;

endpackage
